//--- src/lc4_pkg.sv
//=============================
// LC4 pipeline shared types
// Machine words, opcodes, control, retire and data-memory records
//=============================

package lc4_pkg;

   //=============================
   // Sizes and constants
   //=============================
   localparam int WORD_W    = 16;                // LC4 word width
   localparam int REG_SEL_W = 3;                 // R0..R7
   localparam int NUM_REGS  = 1 << REG_SEL_W;    // 8 registers

   typedef logic [WORD_W-1:0]    word_t;         // Insn, data and address
   typedef logic [REG_SEL_W-1:0] reg_sel_t;      // Register number
   typedef logic [2:0]           nzp_t;          // One-hot N, Z, P

   localparam word_t RESET_PC = 16'h8200;        // First fetch address
   localparam word_t NOP_INSN = 16'h0000;        // Bubble word

   //=============================
   // Encodings
   //=============================
   // Top field of the instruction, only the opcodes this core executes
   typedef enum logic [3:0] {
      OP_NOP     = 4'b0000,   // BR space, always retired as a NOP here
      OP_ARITH   = 4'b0001,   // ADD, MUL, SUB, ADD imm5
      OP_LOGIC   = 4'b0101,   // AND, NOT, OR, XOR, AND imm5
      OP_LDR     = 4'b0110,
      OP_STR     = 4'b0111,
      OP_CONST   = 4'b1001,   // Rd = sext(imm9)
      OP_HICONST = 4'b1101    // Rd = {uimm8, Rd[7:0]}
   } opcode_e;

   // Operation picked by the decoder; PASS is zero so a cleared ctrl is a NOP
   typedef enum logic [3:0] {
      ALU_PASS    = 4'd0,
      ALU_ADD     = 4'd1,
      ALU_ADDI    = 4'd2,     // Also LDR/STR address
      ALU_SUB     = 4'd3,
      ALU_MUL     = 4'd4,
      ALU_AND     = 4'd5,
      ALU_ANDI    = 4'd6,
      ALU_NOT     = 4'd7,
      ALU_OR      = 4'd8,
      ALU_XOR     = 4'd9,
      ALU_CONST   = 4'd10,
      ALU_HICONST = 4'd11
   } alu_op_e;

   //=============================
   // Records
   //=============================
   typedef struct packed {
      reg_sel_t rs_sel;       // First source
      logic     rs_re;
      reg_sel_t rt_sel;       // Second source, STR data
      logic     rt_re;
      reg_sel_t rd_sel;       // Destination
      logic     rd_we;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      alu_op_e  alu_op;
      word_t    imm;          // Already extended to a word
   } ctrl_t;

   typedef struct packed {
      logic     valid;        // Low for bubbles
      word_t    pc;
      word_t    insn;
      logic     rd_we;
      reg_sel_t rd_sel;
      word_t    rd_data;
      logic     nzp_we;
      nzp_t     nzp;
   } retire_t;

   typedef struct packed {
      word_t addr;
      logic  we;
      word_t wdata;
   } dmem_req_t;

endpackage

//--- src/lc4_decoder.sv
//=============================
// LC4 decoder
// Instruction word to the control record carried down the pipe
//=============================
`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::word_t i_insn,   // Word sitting in decode
   output lc4_pkg::ctrl_t o_ctrl    // Control for execute, memory, writeback
);
   import lc4_pkg::*;

   opcode_e    opcode;
   reg_sel_t   rd_f;        // Bits 11:9, STR data source too
   reg_sel_t   rs_f;        // Bits 8:6
   reg_sel_t   rt_f;        // Bits 2:0
   logic [2:0] sub_op;      // ARITH/LOGIC selector
   word_t      imm5;
   word_t      imm6;
   word_t      imm9;
   word_t      uimm8;

   assign opcode = opcode_e'(i_insn[15:12]);
   assign rd_f   = i_insn[11:9];
   assign rs_f   = i_insn[8:6];
   assign rt_f   = i_insn[2:0];
   assign sub_op = i_insn[5:3];
   assign imm5   = {{11{i_insn[4]}}, i_insn[4:0]};  // Sign extended
   assign imm6   = {{10{i_insn[5]}}, i_insn[5:0]};
   assign imm9   = {{7{i_insn[8]}}, i_insn[8:0]};
   assign uimm8  = {8'h00, i_insn[7:0]};            // Zero extended

   always_comb begin
      o_ctrl = '0;                                // Anything unlisted retires as NOP
      case (opcode)
         OP_NOP: o_ctrl = '0;
         OP_ARITH, OP_LOGIC: begin
            o_ctrl.rs_sel = rs_f;
            o_ctrl.rs_re  = 1'b1;
            o_ctrl.rt_sel = rt_f;
            o_ctrl.rt_re  = !sub_op[2];           // Immediate forms skip rt
            o_ctrl.rd_sel = rd_f;
            o_ctrl.rd_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.imm    = imm5;
            if (opcode == OP_ARITH) begin
               case (sub_op)
                  3'b000:  o_ctrl.alu_op = ALU_ADD;
                  3'b001:  o_ctrl.alu_op = ALU_MUL;
                  3'b010:  o_ctrl.alu_op = ALU_SUB;
                  3'b011:  o_ctrl = '0;           // DIV not implemented
                  default: o_ctrl.alu_op = ALU_ADDI;
               endcase
            end else begin
               case (sub_op)
                  3'b000:  o_ctrl.alu_op = ALU_AND;
                  3'b001: begin
                     o_ctrl.alu_op = ALU_NOT;
                     o_ctrl.rt_re  = 1'b0;        // Single source
                  end
                  3'b010:  o_ctrl.alu_op = ALU_OR;
                  3'b011:  o_ctrl.alu_op = ALU_XOR;
                  default: o_ctrl.alu_op = ALU_ANDI;
               endcase
            end
         end
         OP_LDR, OP_STR: begin
            o_ctrl.rs_sel   = rs_f;               // Base register
            o_ctrl.rs_re    = 1'b1;
            o_ctrl.rt_sel   = rd_f;               // Store data
            o_ctrl.rt_re    = (opcode == OP_STR);
            o_ctrl.rd_sel   = rd_f;
            o_ctrl.rd_we    = (opcode == OP_LDR);
            o_ctrl.nzp_we   = (opcode == OP_LDR);
            o_ctrl.is_load  = (opcode == OP_LDR);
            o_ctrl.is_store = (opcode == OP_STR);
            o_ctrl.alu_op   = ALU_ADDI;           // Base + imm6
            o_ctrl.imm      = imm6;
         end
         OP_CONST: begin
            o_ctrl.rd_sel = rd_f;
            o_ctrl.rd_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.alu_op = ALU_CONST;
            o_ctrl.imm    = imm9;
         end
         OP_HICONST: begin
            if (i_insn[8]) begin                  // Bit 8 set marks HICONST
               o_ctrl.rs_sel = rd_f;              // Old Rd feeds the low byte
               o_ctrl.rs_re  = 1'b1;
               o_ctrl.rd_sel = rd_f;
               o_ctrl.rd_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
               o_ctrl.alu_op = ALU_HICONST;
               o_ctrl.imm    = uimm8;
            end
         end
         default: o_ctrl = '0;
      endcase
   end

endmodule

//--- src/lc4_regfile.sv
//=============================
// LC4 register file
// Eight words, two reads, one write with write-through
//=============================
`timescale 1ns/1ps

module lc4_regfile (
   input  logic              gwe,          // Clock
   input  logic              i_reset,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  logic              i_rd_we,
   input  lc4_pkg::word_t    i_rd_data,    // From writeback
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);
   import lc4_pkg::*;

   word_t regs [NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;                      // Architectural state starts at zero
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // Same-cycle write shows up on the read side
   assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_rd_data : regs[i_rt_sel];

endmodule

//--- src/lc4_alu.sv
//=============================
// LC4 ALU
// Arithmetic, logic, constants and load/store addresses
//=============================
`timescale 1ns/1ps

module lc4_alu (
   input  lc4_pkg::alu_op_e i_op,
   input  lc4_pkg::word_t   i_a,          // Rs after bypass
   input  lc4_pkg::word_t   i_b,          // Rt after bypass
   input  lc4_pkg::word_t   i_imm,        // Extended immediate
   input  lc4_pkg::word_t   i_hi_base,    // Old Rd for HICONST
   output lc4_pkg::word_t   o_result
);
   import lc4_pkg::*;

   word_t product;                          // Low half only, LC4 MUL semantics
   word_t hi_const;

   assign product  = i_a * i_b;
   assign hi_const = {i_imm[7:0], i_hi_base[7:0]};  // Upper byte replaced

   always_comb begin
      case (i_op)
         ALU_PASS:    o_result = i_a;
         ALU_ADD:     o_result = i_a + i_b;
         ALU_ADDI:    o_result = i_a + i_imm;       // ADD imm5, LDR/STR address
         ALU_SUB:     o_result = i_a - i_b;
         ALU_MUL:     o_result = product;
         ALU_AND:     o_result = i_a & i_b;
         ALU_ANDI:    o_result = i_a & i_imm;
         ALU_NOT:     o_result = ~i_a;
         ALU_OR:      o_result = i_a | i_b;
         ALU_XOR:     o_result = i_a ^ i_b;
         ALU_CONST:   o_result = i_imm;
         ALU_HICONST: o_result = hi_const;
         default:     o_result = i_a;
      endcase
   end

endmodule

//--- src/lc4_bypass.sv
//=============================
// LC4 bypass and hazard unit
// MX/WX operand forwarding and load-use stall detection
//=============================
`timescale 1ns/1ps

module lc4_bypass (
   input  lc4_pkg::ctrl_t i_ex_ctrl,
   input  lc4_pkg::ctrl_t i_mem_ctrl,
   input  lc4_pkg::ctrl_t i_wb_ctrl,
   input  lc4_pkg::ctrl_t i_dec_ctrl,
   input  lc4_pkg::word_t i_ex_rs,        // Register file values latched in decode
   input  lc4_pkg::word_t i_ex_rt,
   input  lc4_pkg::word_t i_mem_result,   // ALU result in memory stage
   input  lc4_pkg::word_t i_wb_data,      // Final writeback value
   output lc4_pkg::word_t o_op_a,
   output lc4_pkg::word_t o_op_b,
   output logic           o_stall
);
   import lc4_pkg::*;

   logic mx_ok;      // Memory stage has a usable result
   logic ex_load;
   logic rs_hit;
   logic rt_hit;

   // Youngest older writer wins so memory overrides writeback
   function automatic word_t pick(input reg_sel_t sel, input logic re, input word_t rf_val);
      word_t val;
      val = rf_val;
      if (re && i_wb_ctrl.rd_we && (i_wb_ctrl.rd_sel == sel)) begin
         val = i_wb_data;                              // WX
      end
      if (re && mx_ok && (i_mem_ctrl.rd_sel == sel)) begin
         val = i_mem_result;                           // MX
      end
      return val;
   endfunction

   assign mx_ok = i_mem_ctrl.rd_we && !i_mem_ctrl.is_load;  // Load data not back yet

   always_comb begin
      o_op_a = pick(i_ex_ctrl.rs_sel, i_ex_ctrl.rs_re, i_ex_rs);
      o_op_b = pick(i_ex_ctrl.rt_sel, i_ex_ctrl.rt_re, i_ex_rt);
   end

   //=============================
   // Load-use
   //=============================
   assign ex_load = i_ex_ctrl.is_load && i_ex_ctrl.rd_we;
   assign rs_hit  = i_dec_ctrl.rs_re && (i_dec_ctrl.rs_sel == i_ex_ctrl.rd_sel);
   assign rt_hit  = i_dec_ctrl.rt_re && (i_dec_ctrl.rt_sel == i_ex_ctrl.rd_sel);
   assign o_stall = ex_load && (rs_hit || rt_hit);    // Clears once the bubble follows

endmodule

//--- src/lc4_processor.sv
//=============================
// LC4 five-stage pipeline
// Fetch, decode, execute, memory, writeback with a retire trace port
//=============================
`timescale 1ns/1ps

module lc4_processor (
   input  logic               gwe,            // Clock
   input  logic               i_reset,
   output lc4_pkg::word_t     o_imem_addr,    // Fetch address
   input  lc4_pkg::word_t     i_imem_insn,    // Same-cycle instruction
   output lc4_pkg::dmem_req_t o_dmem,         // Memory-stage request
   input  lc4_pkg::word_t     i_dmem_rdata,   // Same-cycle load data
   output lc4_pkg::retire_t   o_retire        // Writeback commit
);
   import lc4_pkg::*;

   logic  stall;
   word_t pc;
   // Decode
   word_t dec_pc, dec_insn, rs_data, rt_data;
   logic  dec_valid;
   ctrl_t dec_ctrl;
   // Execute
   word_t ex_pc, ex_insn, ex_rs, ex_rt, op_a, op_b, alu_result;
   logic  ex_valid;
   ctrl_t ex_ctrl;
   // Memory
   word_t mem_pc, mem_insn, mem_result, mem_rt;
   logic  mem_valid;
   ctrl_t mem_ctrl;
   // Writeback
   word_t wb_pc, wb_insn, wb_result, wb_load_data, wb_data;
   logic  wb_valid;
   ctrl_t wb_ctrl;
   nzp_t  wb_nzp;

   //=============================
   // Control state
   //=============================
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc        <= RESET_PC;
         dec_insn  <= NOP_INSN;
         dec_valid <= 1'b0;
         ex_valid  <= 1'b0;
         ex_ctrl   <= '0;
         mem_valid <= 1'b0;
         mem_ctrl  <= '0;
         wb_valid  <= 1'b0;
         wb_ctrl   <= '0;
      end else begin
         if (!stall) begin                          // Fetch and decode freeze on load-use
            pc        <= pc + 16'h0001;
            dec_insn  <= i_imem_insn;
            dec_valid <= 1'b1;
         end
         ex_valid  <= dec_valid && !stall;          // Bubble is not a retirement
         ex_ctrl   <= stall ? ctrl_t'('0) : dec_ctrl;
         mem_valid <= ex_valid;
         mem_ctrl  <= ex_ctrl;
         wb_valid  <= mem_valid;
         wb_ctrl   <= mem_ctrl;
      end
   end

   //=============================
   // Payload registers
   //=============================
   always_ff @(posedge gwe) begin
      if (!i_reset) begin
         if (!stall) begin
            dec_pc <= pc;
         end
         ex_pc        <= dec_pc;
         ex_insn      <= stall ? NOP_INSN : dec_insn;
         ex_rs        <= rs_data;
         ex_rt        <= rt_data;
         mem_pc       <= ex_pc;
         mem_insn     <= ex_insn;
         mem_result   <= alu_result;
         mem_rt       <= op_b;                      // Store data after bypass
         wb_pc        <= mem_pc;
         wb_insn      <= mem_insn;
         wb_result    <= mem_result;
         wb_load_data <= i_dmem_rdata;
      end
   end

   assign o_imem_addr = pc;

   lc4_decoder lc4_decoder_i (
      .i_insn (dec_insn),
      .o_ctrl (dec_ctrl)
   );

   lc4_regfile lc4_regfile_i (
      .gwe       (gwe),
      .i_reset   (i_reset),
      .i_rs_sel  (dec_ctrl.rs_sel),
      .i_rt_sel  (dec_ctrl.rt_sel),
      .i_rd_sel  (wb_ctrl.rd_sel),
      .i_rd_we   (wb_ctrl.rd_we),
      .i_rd_data (wb_data),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

   lc4_bypass lc4_bypass_i (
      .i_ex_ctrl    (ex_ctrl),
      .i_mem_ctrl   (mem_ctrl),
      .i_wb_ctrl    (wb_ctrl),
      .i_dec_ctrl   (dec_ctrl),
      .i_ex_rs      (ex_rs),
      .i_ex_rt      (ex_rt),
      .i_mem_result (mem_result),
      .i_wb_data    (wb_data),
      .o_op_a       (op_a),
      .o_op_b       (op_b),
      .o_stall      (stall)
   );

   lc4_alu lc4_alu_i (
      .i_op      (ex_ctrl.alu_op),
      .i_a       (op_a),
      .i_b       (op_b),
      .i_imm     (ex_ctrl.imm),
      .i_hi_base (op_a),                            // Rs is Rd for HICONST
      .o_result  (alu_result)
   );

   // Memory stage request, idle bus when not a load or store
   always_comb begin
      o_dmem.addr  = (mem_ctrl.is_load || mem_ctrl.is_store) ? mem_result : '0;
      o_dmem.we    = mem_ctrl.is_store;
      o_dmem.wdata = mem_ctrl.is_store ? mem_rt : '0;
   end

   //=============================
   // Writeback and retire
   //=============================
   assign wb_data = wb_ctrl.is_load ? wb_load_data : wb_result;

   always_comb begin
      if (wb_data[15]) begin
         wb_nzp = 3'b100;                           // Negative
      end else if (wb_data == '0) begin
         wb_nzp = 3'b010;                           // Zero
      end else begin
         wb_nzp = 3'b001;                           // Positive
      end
   end

   always_comb begin
      o_retire.valid   = wb_valid;
      o_retire.pc      = wb_pc;
      o_retire.insn    = wb_insn;
      o_retire.rd_we   = wb_ctrl.rd_we;
      o_retire.rd_sel  = wb_ctrl.rd_sel;
      o_retire.rd_data = wb_data;
      o_retire.nzp_we  = wb_ctrl.nzp_we;
      o_retire.nzp     = wb_nzp;
   end

endmodule

//--- verif/lc4_processor_tb.sv
//=============================
// LC4 pipeline testbench
// Replays a program trace, checks retirements and stores
//=============================
`timescale 1ns/1ps

module lc4_processor_tb;
   import lc4_pkg::*;

   localparam int    HALF_PERIOD  = 50;        // 100 ns clock
   localparam int    RESET_CYCLES = 8;
   localparam int    FIRST_RETIRE = 4;         // Fetch to writeback
   localparam int    REC_WORDS    = 5;         // Tag and four fields per line
   localparam int    TRACE_LINES  = 64;
   localparam word_t FIRST_PC     = 16'h8200;  // LC4 reset vector
   localparam string TRACE_FILE   = "verif/lc4_program_trace.txt";

   logic      gwe;
   logic      reset;
   word_t     imem_addr;
   word_t     imem_insn;
   dmem_req_t dmem_req;
   word_t     dmem_rdata;
   retire_t   retire;

   word_t     imem [65536];
   word_t     dmem [65536];
   word_t     trace_words [REC_WORDS*TRACE_LINES];
   retire_t   exp_retire_q [$];                // Retirements and bubbles in order
   dmem_req_t exp_store_q [$];

   int   errors;
   int   checks;
   int   records;
   int   replayed;
   int   post_cycles;                          // Cycles since reset release
   int   cycle_limit;
   logic timed_out;

   lc4_processor lc4_processor_i (
      .gwe          (gwe),
      .i_reset      (reset),
      .o_imem_addr  (imem_addr),
      .i_imem_insn  (imem_insn),
      .o_dmem       (dmem_req),
      .i_dmem_rdata (dmem_rdata),
      .o_retire     (retire)
   );

   // Both memories answer in the same cycle
   assign imem_insn  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_req.addr];

   initial begin
      gwe = 1'b0;
      forever #HALF_PERIOD gwe = ~gwe;
   end

   task automatic compare_value(input string what, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   //=============================
   // Memory images and trace
   //=============================
   task automatic fill_memories();
      word_t a;
      for (int i = 0; i < 65536; i++) begin
         a       = i[15:0];
         imem[i] = {4'h0, a[11:0] ^ {8'h00, a[15:12]}};  // Opcode 0 makes it a NOP
         dmem[i] = a ^ 16'hC35A;
      end
   endtask

   task automatic load_trace();
      word_t     tag;
      word_t     f_a;
      word_t     f_b;
      word_t     f_c;
      word_t     f_d;
      retire_t   rec;
      dmem_req_t st;
      for (int i = 0; i < REC_WORDS*TRACE_LINES; i++) begin
         trace_words[i] = '0;                  // Tag 0 marks unused lines
      end
      $readmemh(TRACE_FILE, trace_words);
      for (int n = 0; n < TRACE_LINES; n++) begin
         tag = trace_words[REC_WORDS*n];
         f_a = trace_words[REC_WORDS*n+1];
         f_b = trace_words[REC_WORDS*n+2];
         f_c = trace_words[REC_WORDS*n+3];
         f_d = trace_words[REC_WORDS*n+4];
         rec = '0;
         case (tag)
            16'h1: begin                       // Program word and its retirement
               imem[f_a]   = f_b;
               rec.valid   = 1'b1;
               rec.pc      = f_a;
               rec.insn    = f_b;
               rec.rd_data = f_c;
               rec.rd_we   = f_d[12];
               rec.rd_sel  = f_d[10:8];
               rec.nzp_we  = f_d[4];
               rec.nzp     = f_d[2:0];
               exp_retire_q.push_back(rec);
            end
            16'h2: exp_retire_q.push_back(rec); // Load-use bubble
            16'h3: dmem[f_a] = f_b;
            16'h4: begin
               st.addr  = f_a;
               st.we    = 1'b1;
               st.wdata = f_b;
               exp_store_q.push_back(st);
            end
            default: ;
         endcase
      end
      records = exp_retire_q.size();
   endtask

   //=============================
   // Per-cycle checks
   //=============================
   task automatic check_store();
      dmem_req_t exp;
      if (dmem_req.we) begin
         if (exp_store_q.size() == 0) begin
            errors++;
            $display("store of %h to %h at %0t ns was not expected by the trace",
                     dmem_req.wdata, dmem_req.addr, $time);
         end else begin
            exp = exp_store_q.pop_front();
            compare_value("dmem.addr", dmem_req.addr, exp.addr);
            compare_value("dmem.wdata", dmem_req.wdata, exp.wdata);
         end
         dmem[dmem_req.addr] = dmem_req.wdata;  // Visible to the next load
      end
   endtask

   task automatic check_retire();
      retire_t exp;
      if (post_cycles < FIRST_RETIRE) begin
         compare_value("early retire.valid", 16'(retire.valid), 16'h0000);
      end else if (exp_retire_q.size() > 0) begin
         exp = exp_retire_q.pop_front();
         replayed++;
         compare_value("retire.valid", 16'(retire.valid), 16'(exp.valid));
         if (exp.valid) begin
            compare_value("retire.pc", retire.pc, exp.pc);
            compare_value("retire.insn", retire.insn, exp.insn);
            compare_value("retire.rd_we", 16'(retire.rd_we), 16'(exp.rd_we));
            compare_value("retire.nzp_we", 16'(retire.nzp_we), 16'(exp.nzp_we));
            if (exp.rd_we) begin               // Data only matters when written
               compare_value("retire.rd_sel", 16'(retire.rd_sel), 16'(exp.rd_sel));
               compare_value("retire.rd_data", retire.rd_data, exp.rd_data);
            end
            if (exp.nzp_we) begin
               compare_value("retire.nzp", 16'(retire.nzp), 16'(exp.nzp));
            end
         end
      end
   endtask

   //=============================
   // Main sequence
   //=============================
   initial begin
      reset       = 1'b1;
      errors      = 0;
      checks      = 0;
      records     = 0;
      replayed    = 0;
      post_cycles = 0;
      timed_out   = 1'b0;
      fill_memories();
      load_trace();                            // Presets override the fill
      if (records == 0) begin
         errors++;
         $display("trace file %s holds no retire records", TRACE_FILE);
      end
      cycle_limit = 4 * records + 20;
      repeat (RESET_CYCLES) @(negedge gwe);
      reset = 1'b0;
      compare_value("first fetch address", imem_addr, FIRST_PC);
      compare_value("dmem.we after reset", 16'(dmem_req.we), 16'h0000);
      while (exp_retire_q.size() > 0 && !timed_out) begin
         @(negedge gwe);                       // Outputs settled mid-cycle
         post_cycles++;
         check_store();
         check_retire();
         if (post_cycles >= cycle_limit && exp_retire_q.size() > 0) begin
            timed_out = 1'b1;
            errors++;
            $display("the processor did not retire the whole program within %0d cycles",
                     cycle_limit);
         end
      end
      if (exp_store_q.size() > 0) begin
         errors++;
         $display("%0d stores in the trace never appeared on the data port",
                  exp_store_q.size());
      end
      $display("%0d checks, %0d errors, %0d of %0d trace records replayed",
               checks, errors, replayed, records);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- verif/lc4_program_trace.txt
// Fields are tag a b c d in hex. Tag 1 is insn b at pc a retiring rd_data c with flags d
// as rd_we rd_sel nzp_we nzp, 2 a bubble, 3 data b preset at a, 4 a store of b to a
3 003F 1234 0 0
3 0042 0BAD 0 0
4 0042 800C 0 0
4 003E 9242 0 0
// Constants and independent ALU work
1 8200 9205 0005 1111
1 8201 95FD FFFD 1214
1 8202 9600 0000 1312
// Dependent chains at distance one, two and three
1 8203 1842 0002 1411
1 8204 1B09 000A 1511
1 8205 1CD5 FFF6 1614
1 8206 1FBF FFF5 1714
1 8207 53C5 0000 1112
1 8208 5508 FFFD 1214
1 8209 5695 FFFF 1314
1 820A 58DA 0002 1411
1 820B 5AEC 000C 1511
1 820C DB80 800C 1514
1 820D 9C40 0040 1611
// Store then load back, then a preset load with its dependent add
1 820E 7B82 0000 0000
1 820F 6F82 800C 1714
1 8210 63BF 1234 1111
2 0000 0000 0000 0000
1 8211 1444 1236 1211
// NOP, DIV and a shift must leave the registers alone
1 8212 0000 0000 0000
1 8213 165A 0000 0000
1 8214 A7C3 0000 0000
1 8215 18E0 FFFF 1414
1 8216 1A87 9242 1514
1 8217 7BBE 0000 0000
1 8218 61BE 9242 1014

//--- tb.f
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_bypass.sv
src/lc4_processor.sv
verif/lc4_processor_tb.sv

//--- Bender.yml
package:
  name: lc4_pipeline

sources:
  # RTL in compile order
  - src/lc4_pkg.sv
  - src/lc4_decoder.sv
  - src/lc4_regfile.sv
  - src/lc4_alu.sv
  - src/lc4_bypass.sv
  - src/lc4_processor.sv
  # Testbench, top module lc4_processor_tb
  - target: test
    files:
      - verif/lc4_processor_tb.sv
